//--- Makefile
TOP := tb_rec_top

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f flist.f --top-module $(TOP) -Mdir obj_dir -o sim

run: build
	@out=$$(./obj_dir/sim 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q '^RESULT: PASS$$'

lint:
	verilator --lint-only --timing --assert -f flist.f --top-module $(TOP)

clean:
	rm -rf obj_dir

//--- flist.f
source/rec_pkg.sv
source/rec_ctrl.sv
source/rec_residual.sv
source/rec_quant.sv
source/rec_recon.sv
source/rec_top.sv
verification/tb_clock_gen.sv
verification/tb_rec_top.sv

//--- source/rec_ctrl.sv
// rec_ctrl: four-phase input handshake, row counting and per-block mode and qp capture
module rec_ctrl #(
  parameter int PIXEL_WIDTH  = rec_pkg::PIXEL_WIDTH,
  parameter int LANES        = rec_pkg::LANES,
  parameter int ROWS_PER_BLK = rec_pkg::ROWS_PER_BLK
) (
  input  logic                               clk,
  input  logic                               rstn,
  // input handshake
  input  logic                               req_i,
  output logic                               ack_o,
  // block fields, valid with the first row
  input  rec_pkg::slice_type_e               type_i,
  input  logic [rec_pkg::QP_WIDTH-1:0]       qp_i,
  input  logic                               iinp_ena_i,
  input  logic [rec_pkg::COST_WIDTH-1:0]     cost_intra_i,
  input  logic [rec_pkg::COST_WIDTH-1:0]     cost_inter_i,
  // row data
  input  logic [LANES*PIXEL_WIDTH-1:0]       cur_dat_i,
  input  logic [LANES*PIXEL_WIDTH-1:0]       intra_pre_dat_i,
  input  logic [LANES*PIXEL_WIDTH-1:0]       inter_pre_dat_i,
  // to residual stage
  output logic                               row_val_o,
  output rec_pkg::pred_mode_e                mode_o,
  output logic [rec_pkg::QP_WIDTH-1:0]       qp_o,
  output logic                               last_o,
  output logic [LANES*PIXEL_WIDTH-1:0]       cur_o,
  output logic [LANES*PIXEL_WIDTH-1:0]       intra_pre_o,
  output logic [LANES*PIXEL_WIDTH-1:0]       inter_pre_o
);

  import rec_pkg::*;

  localparam int CNT_W = (ROWS_PER_BLK > 1) ? $clog2(ROWS_PER_BLK) : 1;

  logic [CNT_W-1:0] row_cnt;
  logic             capture;
  logic             first_row;
  logic             last_row;
  pred_mode_e       mode_dec;

  // new request seen while ack is still low
  assign capture   = req_i && !ack_o;
  assign first_row = (row_cnt == '0);
  assign last_row  = (row_cnt == CNT_W'(ROWS_PER_BLK - 1));

  // I block in P frame wins on equal cost
  assign mode_dec = ((type_i == SLICE_I) || (iinp_ena_i && (cost_intra_i <= cost_inter_i))) ?
                    MODE_INTRA : MODE_INTER;

  // ------------------------------------------------------------------
  // handshake and row counter
  // ------------------------------------------------------------------

  // ack follows req one cycle later in both directions
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      ack_o     <= 1'b0;
      row_val_o <= 1'b0;
      last_o    <= 1'b0;
      row_cnt   <= '0;
    end else begin
      ack_o     <= req_i;
      row_val_o <= capture;
      if (capture) begin
        last_o  <= last_row;
        row_cnt <= last_row ? '0 : row_cnt + 1'b1;
      end
    end
  end

  // mode and qp are held for the whole block
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      mode_o <= MODE_INTER;
      qp_o   <= '0;
    end else if (capture && first_row) begin
      mode_o <= mode_dec;
      qp_o   <= qp_i;
    end
  end

  // row payload
  always_ff @(posedge clk) begin
    if (capture) begin
      cur_o       <= cur_dat_i;
      intra_pre_o <= intra_pre_dat_i;
      inter_pre_o <= inter_pre_dat_i;
    end
  end

  // ------------------------------------------------------------------
  // checks
  // ------------------------------------------------------------------

  // a rising ack always answers a request
  a_ack_after_req: assert property (@(posedge clk) disable iff (!rstn)
    (!req_i && !ack_o) |=> !ack_o)
    else $error("rec_ctrl: ack_o rose without req_i");

endmodule

//--- source/rec_pkg.sv
// rec_pkg: widths, defaults and enums shared by the 4x4 luma reconstruction datapath
package rec_pkg;

  // ------------------------------------------------------------------
  // default sizes, overridden through module parameters at rec_top
  // ------------------------------------------------------------------

  // sample width of luma
  localparam int PIXEL_WIDTH  = 8;

  // samples carried per block row
  localparam int LANES        = 4;

  // rows in one block
  localparam int ROWS_PER_BLK = 4;

  // ------------------------------------------------------------------
  // fixed field widths
  // ------------------------------------------------------------------

  // hevc qp range 0..51
  localparam int QP_WIDTH     = 6;

  // rate-distortion cost from the mode decision
  localparam int COST_WIDTH   = 20;

  // largest quantizer shift, 51 / 6
  localparam int MAX_SHIFT    = 8;

  // ------------------------------------------------------------------
  // encodings
  // ------------------------------------------------------------------

  // slice type of the current frame
  typedef enum logic {
    SLICE_I = 1'b0,
    SLICE_P = 1'b1
  } slice_type_e;

  // prediction used by the block
  typedef enum logic {
    MODE_INTRA = 1'b0,
    MODE_INTER = 1'b1
  } pred_mode_e;

endpackage

//--- source/rec_quant.sv
// rec_quant: shift quantizer and dequantizer per lane with the block coded flag
module rec_quant #(
  parameter int PIXEL_WIDTH = rec_pkg::PIXEL_WIDTH,
  parameter int LANES       = rec_pkg::LANES
) (
  input  logic                                               clk,
  input  logic                                               rstn,
  input  logic                                               row_val_i,
  input  rec_pkg::pred_mode_e                                mode_i,
  input  logic [rec_pkg::QP_WIDTH-1:0]                       qp_i,
  input  logic                                               last_i,
  input  logic [LANES*PIXEL_WIDTH-1:0]                       pre_i,
  input  logic [LANES*(PIXEL_WIDTH+1)-1:0]                   res_i,
  output logic                                               row_val_o,
  output rec_pkg::pred_mode_e                                mode_o,
  output logic                                               last_o,
  output logic [LANES*PIXEL_WIDTH-1:0]                       pre_o,
  output logic [LANES*(PIXEL_WIDTH+rec_pkg::MAX_SHIFT+1)-1:0] dqres_o,
  output logic                                               cbf_o
);

  import rec_pkg::*;

  localparam int RES_W   = PIXEL_WIDTH + 1;
  localparam int DQ_W    = PIXEL_WIDTH + MAX_SHIFT + 1;
  localparam int SHIFT_W = $clog2((2**QP_WIDTH) / 6 + 1);

  logic [SHIFT_W-1:0]     shift;
  logic [LANES-1:0]       lane_nz;
  logic [LANES*DQ_W-1:0]  dq_w;
  logic                   nz_acc;

  // qp / 6 gives the step as a power of two
  assign shift = SHIFT_W'(qp_i / 6);

  // ------------------------------------------------------------------
  // per lane quantize and dequantize, sign and magnitude
  // ------------------------------------------------------------------
  for (genvar i = 0; i < LANES; i++) begin : g_lane
    logic [RES_W-1:0] res;
    logic             neg;
    logic [RES_W-1:0] mag;
    logic [RES_W-1:0] lvl;
    logic [DQ_W-1:0]  dq_mag;

    assign res    = res_i[i*RES_W +: RES_W];
    assign neg    = res[RES_W-1];
    assign mag    = neg ? -res : res;
    assign lvl    = mag >> shift;
    assign dq_mag = DQ_W'(lvl) << shift;

    assign lane_nz[i]              = |lvl;
    assign dq_w[i*DQ_W +: DQ_W]    = neg ? -dq_mag : dq_mag;
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      row_val_o <= 1'b0;
      last_o    <= 1'b0;
      nz_acc    <= 1'b0;
      cbf_o     <= 1'b0;
    end else begin
      row_val_o <= row_val_i;
      last_o    <= row_val_i && last_i;
      if (row_val_i) begin
        // fold the row into the block flag, restart after the last row
        if (last_i) begin
          cbf_o  <= nz_acc || (|lane_nz);
          nz_acc <= 1'b0;
        end else begin
          nz_acc <= nz_acc || (|lane_nz);
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    mode_o  <= mode_i;
    pre_o   <= pre_i;
    dqres_o <= dq_w;
  end

  // qp stays within the hevc range
  a_shift_range: assert property (@(posedge clk) disable iff (!rstn)
    row_val_i |-> (shift <= SHIFT_W'(MAX_SHIFT)))
    else $error("rec_quant: shift %0d above MAX_SHIFT", shift);

endmodule

//--- source/rec_recon.sv
// rec_recon: adds prediction and dequantized residual, clips and presents the row
module rec_recon #(
  parameter int PIXEL_WIDTH = rec_pkg::PIXEL_WIDTH,
  parameter int LANES       = rec_pkg::LANES
) (
  input  logic                                               clk,
  input  logic                                               rstn,
  input  logic                                               row_val_i,
  input  rec_pkg::pred_mode_e                                mode_i,
  input  logic                                               last_i,
  input  logic [LANES*PIXEL_WIDTH-1:0]                       pre_i,
  input  logic [LANES*(PIXEL_WIDTH+rec_pkg::MAX_SHIFT+1)-1:0] dqres_i,
  input  logic                                               cbf_i,
  output logic                                               rec_val_o,
  output logic [LANES*PIXEL_WIDTH-1:0]                       rec_dat_o,
  output rec_pkg::pred_mode_e                                rec_mode_o,
  output logic                                               done_o,
  output logic                                               cbf_o
);

  import rec_pkg::*;

  localparam int DQ_W  = PIXEL_WIDTH + MAX_SHIFT + 1;
  localparam int SUM_W = DQ_W + 1;

  logic [LANES*PIXEL_WIDTH-1:0] rec_w;

  // ------------------------------------------------------------------
  // add and clip to 0 .. 2^PIXEL_WIDTH-1
  // ------------------------------------------------------------------
  for (genvar i = 0; i < LANES; i++) begin : g_lane
    logic [DQ_W-1:0]  dq;
    logic [SUM_W-1:0] sum;

    assign dq  = dqres_i[i*DQ_W +: DQ_W];
    assign sum = $signed({{(SUM_W-PIXEL_WIDTH){1'b0}}, pre_i[i*PIXEL_WIDTH +: PIXEL_WIDTH]})
               + $signed({dq[DQ_W-1], dq});

    // negative clips to zero, any high bit clips to full scale
    assign rec_w[i*PIXEL_WIDTH +: PIXEL_WIDTH] =
      sum[SUM_W-1]                 ? '0 :
      (|sum[SUM_W-2:PIXEL_WIDTH])  ? '1 :
                                     sum[PIXEL_WIDTH-1:0];
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      rec_val_o <= 1'b0;
      done_o    <= 1'b0;
      cbf_o     <= 1'b0;
    end else begin
      rec_val_o <= row_val_i;
      done_o    <= row_val_i && last_i;
      if (row_val_i && last_i) begin
        cbf_o <= cbf_i;
      end
    end
  end

  always_ff @(posedge clk) begin
    rec_dat_o  <= rec_w;
    rec_mode_o <= mode_i;
  end

  a_done_with_row: assert property (@(posedge clk) disable iff (!rstn)
    done_o |-> rec_val_o)
    else $error("rec_recon: done_o without rec_val_o");

endmodule

//--- source/rec_residual.sv
// rec_residual: selects the prediction for the block mode and forms the signed residual
module rec_residual #(
  parameter int PIXEL_WIDTH = rec_pkg::PIXEL_WIDTH,
  parameter int LANES       = rec_pkg::LANES
) (
  input  logic                               clk,
  input  logic                               rstn,
  input  logic                               row_val_i,
  input  rec_pkg::pred_mode_e                mode_i,
  input  logic [rec_pkg::QP_WIDTH-1:0]       qp_i,
  input  logic                               last_i,
  input  logic [LANES*PIXEL_WIDTH-1:0]       cur_i,
  input  logic [LANES*PIXEL_WIDTH-1:0]       intra_pre_i,
  input  logic [LANES*PIXEL_WIDTH-1:0]       inter_pre_i,
  output logic                               row_val_o,
  output rec_pkg::pred_mode_e                mode_o,
  output logic [rec_pkg::QP_WIDTH-1:0]       qp_o,
  output logic                               last_o,
  output logic [LANES*PIXEL_WIDTH-1:0]       pre_o,
  output logic [LANES*(PIXEL_WIDTH+1)-1:0]   res_o
);

  import rec_pkg::*;

  localparam int RES_W = PIXEL_WIDTH + 1;

  logic [LANES*PIXEL_WIDTH-1:0] pre_sel;
  logic [LANES*RES_W-1:0]       res_w;

  assign pre_sel = (mode_i == MODE_INTRA) ? intra_pre_i : inter_pre_i;

  // cur minus pre per lane, one extra bit for the sign
  for (genvar i = 0; i < LANES; i++) begin : g_lane
    assign res_w[i*RES_W +: RES_W] = $signed({1'b0, cur_i[i*PIXEL_WIDTH +: PIXEL_WIDTH]})
                                   - $signed({1'b0, pre_sel[i*PIXEL_WIDTH +: PIXEL_WIDTH]});
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      row_val_o <= 1'b0;
      last_o    <= 1'b0;
    end else begin
      row_val_o <= row_val_i;
      last_o    <= row_val_i && last_i;
    end
  end

  // side fields and payload
  always_ff @(posedge clk) begin
    mode_o <= mode_i;
    qp_o   <= qp_i;
    pre_o  <= pre_sel;
    res_o  <= res_w;
  end

endmodule

//--- source/rec_top.sv
// rec_top: reconstruction datapath for 4x4 luma blocks, four registered stages
module rec_top #(
  parameter int PIXEL_WIDTH  = rec_pkg::PIXEL_WIDTH,
  parameter int LANES        = rec_pkg::LANES,
  parameter int ROWS_PER_BLK = rec_pkg::ROWS_PER_BLK
) (
  input  logic                               clk,
  input  logic                               rstn,
  // input handshake
  input  logic                               req_i,
  output logic                               ack_o,
  // block fields
  input  rec_pkg::slice_type_e               type_i,
  input  logic [rec_pkg::QP_WIDTH-1:0]       qp_i,
  input  logic                               iinp_ena_i,
  input  logic [rec_pkg::COST_WIDTH-1:0]     cost_intra_i,
  input  logic [rec_pkg::COST_WIDTH-1:0]     cost_inter_i,
  // row data
  input  logic [LANES*PIXEL_WIDTH-1:0]       cur_dat_i,
  input  logic [LANES*PIXEL_WIDTH-1:0]       intra_pre_dat_i,
  input  logic [LANES*PIXEL_WIDTH-1:0]       inter_pre_dat_i,
  // reconstructed rows
  output logic                               rec_val_o,
  output logic [LANES*PIXEL_WIDTH-1:0]       rec_dat_o,
  output rec_pkg::pred_mode_e                rec_mode_o,
  output logic                               done_o,
  output logic                               cbf_o
);

  import rec_pkg::*;

  localparam int RES_W = PIXEL_WIDTH + 1;
  localparam int DQ_W  = PIXEL_WIDTH + MAX_SHIFT + 1;

  // ------------------------------------------------------------------
  // stage links
  // ------------------------------------------------------------------

  // ctrl to residual
  logic                         c_val, c_last;
  pred_mode_e                   c_mode;
  logic [QP_WIDTH-1:0]          c_qp;
  logic [LANES*PIXEL_WIDTH-1:0] c_cur, c_intra, c_inter;

  // residual to quant
  logic                         r_val, r_last;
  pred_mode_e                   r_mode;
  logic [QP_WIDTH-1:0]          r_qp;
  logic [LANES*PIXEL_WIDTH-1:0] r_pre;
  logic [LANES*RES_W-1:0]       r_res;

  // quant to recon
  logic                         q_val, q_last, q_cbf;
  pred_mode_e                   q_mode;
  logic [LANES*PIXEL_WIDTH-1:0] q_pre;
  logic [LANES*DQ_W-1:0]        q_dq;

  rec_ctrl #(
    .PIXEL_WIDTH  (PIXEL_WIDTH),
    .LANES        (LANES),
    .ROWS_PER_BLK (ROWS_PER_BLK)
  ) u_ctrl (
    .clk             (clk),
    .rstn            (rstn),
    .req_i           (req_i),
    .ack_o           (ack_o),
    .type_i          (type_i),
    .qp_i            (qp_i),
    .iinp_ena_i      (iinp_ena_i),
    .cost_intra_i    (cost_intra_i),
    .cost_inter_i    (cost_inter_i),
    .cur_dat_i       (cur_dat_i),
    .intra_pre_dat_i (intra_pre_dat_i),
    .inter_pre_dat_i (inter_pre_dat_i),
    .row_val_o       (c_val),
    .mode_o          (c_mode),
    .qp_o            (c_qp),
    .last_o          (c_last),
    .cur_o           (c_cur),
    .intra_pre_o     (c_intra),
    .inter_pre_o     (c_inter)
  );

  rec_residual #(
    .PIXEL_WIDTH (PIXEL_WIDTH),
    .LANES       (LANES)
  ) u_residual (
    .clk         (clk),
    .rstn        (rstn),
    .row_val_i   (c_val),
    .mode_i      (c_mode),
    .qp_i        (c_qp),
    .last_i      (c_last),
    .cur_i       (c_cur),
    .intra_pre_i (c_intra),
    .inter_pre_i (c_inter),
    .row_val_o   (r_val),
    .mode_o      (r_mode),
    .qp_o        (r_qp),
    .last_o      (r_last),
    .pre_o       (r_pre),
    .res_o       (r_res)
  );

  rec_quant #(
    .PIXEL_WIDTH (PIXEL_WIDTH),
    .LANES       (LANES)
  ) u_quant (
    .clk       (clk),
    .rstn      (rstn),
    .row_val_i (r_val),
    .mode_i    (r_mode),
    .qp_i      (r_qp),
    .last_i    (r_last),
    .pre_i     (r_pre),
    .res_i     (r_res),
    .row_val_o (q_val),
    .mode_o    (q_mode),
    .last_o    (q_last),
    .pre_o     (q_pre),
    .dqres_o   (q_dq),
    .cbf_o     (q_cbf)
  );

  rec_recon #(
    .PIXEL_WIDTH (PIXEL_WIDTH),
    .LANES       (LANES)
  ) u_recon (
    .clk        (clk),
    .rstn       (rstn),
    .row_val_i  (q_val),
    .mode_i     (q_mode),
    .last_i     (q_last),
    .pre_i      (q_pre),
    .dqres_i    (q_dq),
    .cbf_i      (q_cbf),
    .rec_val_o  (rec_val_o),
    .rec_dat_o  (rec_dat_o),
    .rec_mode_o (rec_mode_o),
    .done_o     (done_o),
    .cbf_o      (cbf_o)
  );

endmodule

//--- verification/tb_clock_gen.sv
// tb_clock_gen: free running testbench clock and power-on reset for the datapath
module tb_clock_gen #(
  parameter int PERIOD_NS    = 100,
  parameter int RESET_CYCLES = 3
) (
  output logic clk_o,
  output logic rstn_o
);

  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // release on a falling edge, clear of the rising edge
  initial begin
    rstn_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rstn_o = 1'b1;
  end

endmodule

//--- verification/tb_rec_top.sv
// tb_rec_top: random and directed blocks through the reconstruction datapath, checked by assertions
module tb_rec_top;

  timeunit 1ns;
  timeprecision 100ps;

  import rec_pkg::*;

  localparam int          PW         = PIXEL_WIDTH;
  localparam int          DW         = LANES * PIXEL_WIDTH;
  localparam int          NUM_BLOCKS = 40;
  localparam int          MAX_CYCLES = NUM_BLOCKS * ROWS_PER_BLK * 8 + 200;
  localparam logic [31:0] SEED       = 32'hf1ee9aed;

  logic                  clk;
  logic                  rstn;
  logic                  req;
  logic                  ack;
  slice_type_e           type_sel;
  logic [QP_WIDTH-1:0]   qp;
  logic                  iinp_ena;
  logic [COST_WIDTH-1:0] cost_intra;
  logic [COST_WIDTH-1:0] cost_inter;
  logic [DW-1:0]         cur_dat;
  logic [DW-1:0]         intra_pre_dat;
  logic [DW-1:0]         inter_pre_dat;
  logic                  rec_val;
  logic [DW-1:0]         rec_dat;
  pred_mode_e            rec_mode;
  logic                  done;
  logic                  cbf;

  // expected rows in output order
  logic [DW-1:0] exp_dat_q[$];
  pred_mode_e    exp_mode_q[$];
  logic          exp_last_q[$];
  logic          exp_cbf_q[$];

  // row currently on the output
  logic [DW-1:0] exp_dat;
  pred_mode_e    exp_mode;
  logic          exp_last;
  logic          exp_cbf;
  logic          exp_avail = 1'b0;
  int            out_idx   = 0;

  logic [31:0] rng_state;
  int          cycle_cnt = 0;
  int          cnt_cat[4];
  int          cnt_cbf0 = 0;
  int          cnt_cbf1 = 0;
  int          hit_min  = 0;
  int          hit_max  = 0;

  tb_clock_gen i_clk_gen (
    .clk_o  (clk),
    .rstn_o (rstn)
  );

  rec_top i_dut (
    .clk             (clk),
    .rstn            (rstn),
    .req_i           (req),
    .ack_o           (ack),
    .type_i          (type_sel),
    .qp_i            (qp),
    .iinp_ena_i      (iinp_ena),
    .cost_intra_i    (cost_intra),
    .cost_inter_i    (cost_inter),
    .cur_dat_i       (cur_dat),
    .intra_pre_dat_i (intra_pre_dat),
    .inter_pre_dat_i (inter_pre_dat),
    .rec_val_o       (rec_val),
    .rec_dat_o       (rec_dat),
    .rec_mode_o      (rec_mode),
    .done_o          (done),
    .cbf_o           (cbf)
  );

  // ------------------------------------------------------------------
  // failure reporting
  // ------------------------------------------------------------------

  task automatic report_fail(input string what);
    $display("%s", what);
    $display("RESULT: FAIL");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
    report_fail($sformatf("Error: %s = 0x%0h, expected 0x%0h", name, got, exp));
  endtask

  // ------------------------------------------------------------------
  // random numbers and reference model
  // ------------------------------------------------------------------

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // intra for I slices, or an I block in a P frame that is no dearer
  function automatic pred_mode_e decide_mode(input slice_type_e t, input logic ena,
                                             input logic [COST_WIDTH-1:0] ci,
                                             input logic [COST_WIDTH-1:0] ce);
    if (t == SLICE_I) return MODE_INTRA;
    if (ena && (ci <= ce)) return MODE_INTRA;
    return MODE_INTER;
  endfunction

  // quantize, dequantize, add and clip one sample
  task automatic model_lane(input logic [PW-1:0] c, input logic [PW-1:0] p,
                            input logic [QP_WIDTH-1:0] q,
                            output logic [PW-1:0] rec, output logic nz);
    int diff;
    int step;
    int lvl;
    int dq;
    int sum;
    diff = int'(c) - int'(p);
    step = int'(q) / 6;
    lvl  = ((diff < 0) ? -diff : diff) >> step;
    dq   = (diff < 0) ? -(lvl << step) : (lvl << step);
    sum  = int'(p) + dq;
    nz   = (lvl != 0);
    if (sum < 0) rec = '0;
    else if (sum > (1 << PW) - 1) rec = '1;
    else rec = PW'(sum);
  endtask

  // ------------------------------------------------------------------
  // four-phase driver
  // ------------------------------------------------------------------

  task automatic send_row(input logic [DW-1:0] cur, input logic [DW-1:0] intra,
                          input logic [DW-1:0] inter);
    @(negedge clk);
    cur_dat       = cur;
    intra_pre_dat = intra;
    inter_pre_dat = inter;
    req           = 1'b1;
    do @(negedge clk); while (!ack);
    req = 1'b0;
    do @(negedge clk); while (ack);
  endtask

  // block kind by index: %4 picks the mode case, %10 == 1 hits the range ends,
  // %10 == 4 makes cur equal to both predictions
  task automatic send_block(input int blk);
    slice_type_e           t;
    logic                  ena;
    logic [COST_WIDTH-1:0] ci;
    logic [COST_WIDTH-1:0] ce;
    logic [QP_WIDTH-1:0]   q;
    pred_mode_e            m;
    logic                  nz;
    logic                  lane_nz;
    logic [PW-1:0]         c;
    logic [PW-1:0]         pi;
    logic [PW-1:0]         pe;
    logic [PW-1:0]         e;
    logic [DW-1:0]         cur;
    logic [DW-1:0]         intra;
    logic [DW-1:0]         inter;
    logic [DW-1:0]         exp_row;
    ci  = COST_WIDTH'(next_rand());
    ce  = COST_WIDTH'(next_rand() % 32'h80000);
    ena = 1'(next_rand() >> 7);
    case (blk % 4)
      0: t = SLICE_I;
      1: begin
        t   = SLICE_P;
        ena = 1'b0;
      end
      2: begin
        t   = SLICE_P;
        ena = 1'b1;
        ci  = (blk % 8 == 2) ? ce : (ce >> 1);
      end
      default: begin
        t   = SLICE_P;
        ena = 1'b1;
        ci  = ce + 1 + COST_WIDTH'(next_rand() % 1000);
      end
    endcase
    cnt_cat[blk % 4]++;
    q  = QP_WIDTH'(next_rand() % ((blk < 12) ? 6 : 52));
    m  = decide_mode(t, ena, ci, ce);
    nz = 1'b0;
    // fields change only while req and ack are both low
    type_sel   = t;
    qp         = q;
    iinp_ena   = ena;
    cost_intra = ci;
    cost_inter = ce;
    for (int r = 0; r < ROWS_PER_BLK; r++) begin
      for (int l = 0; l < LANES; l++) begin
        if (blk % 10 == 1) begin
          c  = ((l + r) % 2 == 0) ? '0 : '1;
          pi = ~c;
          pe = ~c;
        end else begin
          c  = PW'(next_rand());
          pi = (blk % 10 == 4) ? c : PW'(next_rand());
          pe = (blk % 10 == 4) ? c : PW'(next_rand());
        end
        model_lane(c, (m == MODE_INTRA) ? pi : pe, q, e, lane_nz);
        nz = nz | lane_nz;
        if (q < 6 && e == '0) hit_min++;
        if (q < 6 && e == '1) hit_max++;
        cur[l*PW +: PW]     = c;
        intra[l*PW +: PW]   = pi;
        inter[l*PW +: PW]   = pe;
        exp_row[l*PW +: PW] = e;
      end
      exp_dat_q.push_back(exp_row);
      exp_mode_q.push_back(m);
      exp_last_q.push_back(r == ROWS_PER_BLK - 1);
      exp_cbf_q.push_back(nz);
      send_row(cur, intra, inter);
    end
    if (nz) cnt_cbf1++;
    else cnt_cbf0++;
  endtask

  // ------------------------------------------------------------------
  // output tracking and run limit
  // ------------------------------------------------------------------

  // a row shown now is checked at the next rising edge
  always @(negedge clk) begin
    if (rec_val) begin
      exp_avail <= (out_idx < exp_dat_q.size());
      if (out_idx < exp_dat_q.size()) begin
        exp_dat  <= exp_dat_q[out_idx];
        exp_mode <= exp_mode_q[out_idx];
        exp_last <= exp_last_q[out_idx];
        exp_cbf  <= exp_cbf_q[out_idx];
      end
      out_idx = out_idx + 1;
    end
  end

  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      report_fail("Timeout: the datapath did not finish all blocks in time");
    end
  end

  // ------------------------------------------------------------------
  // checks
  // ------------------------------------------------------------------

  a_reset_quiet: assert property (@(posedge clk) $rose(rstn) |-> (!ack && !rec_val && !done))
    else report_fail("ack_o, rec_val_o or done_o was high coming out of reset");

  a_ack_rise: assert property (@(posedge clk) disable iff (!rstn) req |=> ack)
    else report_fail("ack_o did not rise one cycle after req_i was high");

  a_ack_fall: assert property (@(posedge clk) disable iff (!rstn) !req |=> !ack)
    else report_fail("ack_o did not fall one cycle after req_i was low");

  a_latency: assert property (@(posedge clk) disable iff (!rstn)
    $rose(ack) |-> ##3 rec_val ##1 !rec_val)
    else report_fail("rec_val_o was not a single pulse three cycles after ack_o rose");

  a_val_source: assert property (@(posedge clk) disable iff (!rstn)
    rec_val |-> ($past(ack, 3) && !$past(ack, 4)))
    else report_fail("rec_val_o pulsed without an ack_o rise three cycles before");

  a_row_expected: assert property (@(posedge clk) disable iff (!rstn) rec_val |-> exp_avail)
    else report_fail("rec_val_o showed a row that was never sent");

  a_rec_dat: assert property (@(posedge clk) disable iff (!rstn)
    rec_val |-> (rec_dat == exp_dat))
    else report_mismatch("rec_dat_o", 64'($sampled(rec_dat)), 64'($sampled(exp_dat)));

  a_rec_mode: assert property (@(posedge clk) disable iff (!rstn)
    rec_val |-> (rec_mode == exp_mode))
    else report_mismatch("rec_mode_o", 64'($sampled(rec_mode)), 64'($sampled(exp_mode)));

  a_done: assert property (@(posedge clk) disable iff (!rstn)
    rec_val |-> (done == exp_last))
    else report_mismatch("done_o", 64'($sampled(done)), 64'($sampled(exp_last)));

  a_done_only_with_row: assert property (@(posedge clk) disable iff (!rstn) !rec_val |-> !done)
    else report_fail("done_o was high without rec_val_o");

  a_cbf: assert property (@(posedge clk) disable iff (!rstn) done |-> (cbf == exp_cbf))
    else report_mismatch("cbf_o", 64'($sampled(cbf)), 64'($sampled(exp_cbf)));

  // ------------------------------------------------------------------
  // stimulus
  // ------------------------------------------------------------------

  initial begin
    req           = 1'b0;
    type_sel      = SLICE_I;
    qp            = '0;
    iinp_ena      = 1'b0;
    cost_intra    = '0;
    cost_inter    = '0;
    cur_dat       = '0;
    intra_pre_dat = '0;
    inter_pre_dat = '0;
    rng_state     = SEED;
    for (int k = 0; k < 4; k++) cnt_cat[k] = 0;
    @(posedge rstn);
    @(negedge clk);
    for (int blk = 0; blk < NUM_BLOCKS; blk++) begin
      send_block(blk);
      repeat (int'(next_rand() % 3)) @(negedge clk);
    end
    while (out_idx < exp_dat_q.size()) @(negedge clk);
    repeat (2) @(negedge clk);
    if (cnt_cat[0] > 0 && cnt_cat[1] > 0 && cnt_cat[2] > 0 && cnt_cat[3] > 0 &&
        cnt_cbf0 > 0 && cnt_cbf1 > 0 && hit_min > 0 && hit_max > 0 &&
        out_idx == exp_dat_q.size()) begin
      $display("RESULT: PASS");
      $finish;
    end else begin
      report_fail("Stimulus missed a mode, cbf or range case, or rows went missing");
    end
  end

endmodule
